//--- logic/cop_pkg.sv
// Co-processor widths, encoding layout, class and subclass codes, result codes, FSM and LFSR constants
package cop_pkg;

    localparam int XLEN      = 32;          // Word width
    localparam int CPR_COUNT = 16;          // Co-processor registers
    localparam int CPR_AW    = 4;           // CPR address width
    localparam int GPR_AW    = 5;           // CPU register address width
    localparam int IMM_W     = 9;           // I-form immediate width

    localparam logic [6:0] COP_OPCODE = 7'b0001011; // custom-0 major opcode

    // Instruction classes, bits 31..28
    typedef logic [3:0] cop_class_t;
    localparam cop_class_t ICLASS_MOVE    = 4'd1;
    localparam cop_class_t ICLASS_BITWISE = 4'd2;
    localparam cop_class_t ICLASS_RANDOM  = 4'd3;

    // Subclasses, bits 27..24, unique across all classes
    typedef logic [3:0] cop_sclass_t;
    localparam cop_sclass_t SCLASS_GPR2XCR = 4'd0;
    localparam cop_sclass_t SCLASS_XCR2GPR = 4'd1;
    localparam cop_sclass_t SCLASS_LDI     = 4'd2;
    localparam cop_sclass_t SCLASS_AND     = 4'd3;
    localparam cop_sclass_t SCLASS_OR      = 4'd4;
    localparam cop_sclass_t SCLASS_XOR     = 4'd5;
    localparam cop_sclass_t SCLASS_NOT     = 4'd6;
    localparam cop_sclass_t SCLASS_RSEED   = 4'd7;
    localparam cop_sclass_t SCLASS_RSAMP   = 4'd8;
    localparam cop_sclass_t SCLASS_RTEST   = 4'd9;

    // Instruction result codes
    typedef logic [2:0] cop_result_t;
    localparam cop_result_t INSN_SUCCESS = 3'd0;
    localparam cop_result_t INSN_BAD_INS = 3'd1;

    // Handshake FSM states
    localparam logic [1:0] FSM_IDLE      = 2'd0;
    localparam logic [1:0] FSM_WAITING   = 2'd1;
    localparam logic [1:0] FSM_EXECUTING = 2'd2;
    localparam logic [1:0] FSM_FINISHED  = 2'd3;

    localparam logic [XLEN-1:0] LFSR_TAPS = 32'h8020_0003; // x^32+x^22+x^2+x+1
    localparam int              RNG_STEPS = 4;              // Shifts per sample
    localparam int              RNG_CW    = $clog2(RNG_STEPS + 1); // Step counter width

    // Register form, CPR source pair plus a GPR index
    typedef struct packed {
        cop_class_t        iclass;  // 31..28
        cop_sclass_t       sclass;  // 27..24
        logic [CPR_AW-1:0] crs2;    // 23..20
        logic [GPR_AW-1:0] gpr;     // 19..15
        logic [CPR_AW-1:0] crs1;    // 14..11
        logic [CPR_AW-1:0] crd;     // 10..7
        logic [6:0]        opcode;  // 6..0
    } cop_rform_t;

    // Immediate form, shares the outer fields
    typedef struct packed {
        cop_class_t        iclass;
        cop_sclass_t       sclass;
        logic [IMM_W-1:0]  imm;     // 23..15
        logic [CPR_AW-1:0] crs1;
        logic [CPR_AW-1:0] crd;
        logic [6:0]        opcode;
    } cop_iform_t;

    typedef union packed {
        cop_rform_t r;              // Register view
        cop_iform_t i;              // Immediate view
    } cop_insn_u;

endpackage

//--- logic/cop_decode.sv
// Instruction decoder producing fields, class, subclass and illegal-instruction flag
`timescale 1ns/1ps
module cop_decode (
    input  logic [cop_pkg::XLEN-1:0]   insn_enc,     // Encoded instruction
    output logic                       id_exception, // Illegal instruction
    output cop_pkg::cop_class_t        id_class,     // Instruction class
    output cop_pkg::cop_sclass_t       id_subclass,  // Instruction subclass
    output logic [cop_pkg::CPR_AW-1:0] id_crd,       // CPR destination
    output logic [cop_pkg::CPR_AW-1:0] id_crs1,      // CPR source 1
    output logic [cop_pkg::CPR_AW-1:0] id_crs2,      // CPR source 2
    output logic [cop_pkg::GPR_AW-1:0] id_gpr,       // GPR destination
    output logic [cop_pkg::XLEN-1:0]   id_imm        // Zero-extended immediate
);
    import cop_pkg::*;

    cop_insn_u insn;                                 // Two views of one word
    logic      bad_opcode;
    logic      bad_class;
    logic      bad_sclass;

    assign insn = insn_enc;

    assign id_class    = insn.r.iclass;
    assign id_subclass = insn.r.sclass;
    assign id_crd      = insn.r.crd;
    assign id_crs1     = insn.r.crs1;
    assign id_crs2     = insn.r.crs2;                // Overlaps imm high bits
    assign id_gpr      = insn.r.gpr;
    assign id_imm      = {{(XLEN-IMM_W){1'b0}}, insn.i.imm};

    assign bad_opcode = insn.r.opcode != COP_OPCODE; // Not custom-0

    // Subclass must belong to its class
    always_comb begin
        bad_class  = 1'b0;
        bad_sclass = 1'b0;
        case (id_class)
            ICLASS_MOVE: bad_sclass =
                !(id_subclass inside {SCLASS_GPR2XCR, SCLASS_XCR2GPR, SCLASS_LDI});
            ICLASS_BITWISE: bad_sclass =
                !(id_subclass inside {SCLASS_AND, SCLASS_OR, SCLASS_XOR, SCLASS_NOT});
            ICLASS_RANDOM: bad_sclass =
                !(id_subclass inside {SCLASS_RSEED, SCLASS_RSAMP, SCLASS_RTEST});
            default: bad_class = 1'b1;               // Unknown class
        endcase
    end

    assign id_exception = bad_opcode | bad_class | bad_sclass;

endmodule

//--- logic/cop_cprs.sv
// Co-processor register file, sixteen words, two read ports and one write port
`timescale 1ns/1ps
module cop_cprs (
    input  logic                       g_clk,
    input  logic                       g_resetn,
    input  logic [cop_pkg::CPR_AW-1:0] crs1_addr,  // Read port 1 address
    output logic [cop_pkg::XLEN-1:0]   crs1_rdata, // Read port 1 data
    input  logic [cop_pkg::CPR_AW-1:0] crs2_addr,  // Read port 2 address
    output logic [cop_pkg::XLEN-1:0]   crs2_rdata, // Read port 2 data
    input  logic                       crd_wen,    // Full-word write
    input  logic [cop_pkg::CPR_AW-1:0] crd_addr,
    input  logic [cop_pkg::XLEN-1:0]   crd_wdata
);
    import cop_pkg::*;

    logic [XLEN-1:0] regs [CPR_COUNT];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            foreach (regs[i]) begin
                regs[i] <= '0;                      // Clear all CPRs
            end
        end else if (crd_wen) begin
            regs[crd_addr] <= crd_wdata;
        end
    end

    // Reads are combinational
    assign crs1_rdata = regs[crs1_addr];
    assign crs2_rdata = regs[crs2_addr];

endmodule

//--- logic/cop_palu.sv
// Single-cycle move, load-immediate and bitwise logic unit
`timescale 1ns/1ps
module cop_palu (
    input  logic                     palu_ivalid, // Dispatch from control
    input  cop_pkg::cop_sclass_t     id_subclass,
    input  logic [cop_pkg::XLEN-1:0] gpr_rs1,     // CPU rs1 value
    input  logic [cop_pkg::XLEN-1:0] crs1_rdata,
    input  logic [cop_pkg::XLEN-1:0] crs2_rdata,
    input  logic [cop_pkg::XLEN-1:0] id_imm,
    output logic                     palu_done,
    output logic                     palu_wen,    // CPR write
    output logic [cop_pkg::XLEN-1:0] palu_wdata
);
    import cop_pkg::*;

    logic            res_wen;                     // Raw CPR write
    logic [XLEN-1:0] res_data;                    // Raw result

    always_comb begin
        res_wen  = 1'b1;
        res_data = '0;
        case (id_subclass)
            SCLASS_GPR2XCR: res_data = gpr_rs1;
            SCLASS_XCR2GPR: begin
                res_data = crs1_rdata;            // To GPR only
                res_wen  = 1'b0;
            end
            SCLASS_LDI:     res_data = id_imm;
            SCLASS_AND:     res_data = crs1_rdata & crs2_rdata;
            SCLASS_OR:      res_data = crs1_rdata | crs2_rdata;
            SCLASS_XOR:     res_data = crs1_rdata ^ crs2_rdata;
            SCLASS_NOT:     res_data = ~crs1_rdata;
            default:        res_wen  = 1'b0;
        endcase
    end

    assign palu_done  = palu_ivalid;              // Always one cycle
    assign palu_wen   = palu_ivalid & res_wen;
    assign palu_wdata = {XLEN{palu_ivalid}} & res_data; // Zero when idle

endmodule

//--- logic/cop_rng.sv
// LFSR random unit with seed, multi-step sample and nonzero test
`timescale 1ns/1ps
module cop_rng (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  logic                     rng_ivalid,  // Held until done
    input  cop_pkg::cop_sclass_t     id_subclass,
    input  logic [cop_pkg::XLEN-1:0] crs1_rdata,  // Seed source
    output logic                     rng_done,
    output logic                     rng_wen,
    output logic [cop_pkg::XLEN-1:0] rng_wdata
);
    import cop_pkg::*;

    logic [XLEN-1:0]   lfsr;                      // Generator state
    logic [XLEN-1:0]   lfsr_step;                 // One Galois shift
    logic [RNG_CW-1:0] step_cnt;                  // Shifts so far
    logic              is_seed;
    logic              is_samp;
    logic              is_test;
    logic              samp_last;                 // All shifts taken

    assign is_seed   = rng_ivalid && (id_subclass == SCLASS_RSEED);
    assign is_samp   = rng_ivalid && (id_subclass == SCLASS_RSAMP);
    assign is_test   = rng_ivalid && (id_subclass == SCLASS_RTEST);
    assign samp_last = step_cnt == RNG_CW'(RNG_STEPS);

    // Right shift, taps folded in when bit 0 falls out, zero stays zero
    assign lfsr_step = {1'b0, lfsr[XLEN-1:1]} ^ (lfsr[0] ? LFSR_TAPS : '0);

    assign rng_done  = rng_ivalid && (!is_samp || samp_last);
    assign rng_wen   = is_samp && samp_last;      // Sample lands in crd
    assign rng_wdata = is_test ? {{(XLEN-1){1'b0}}, |lfsr} :
                       rng_wen ? lfsr : '0;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            lfsr     <= '0;
            step_cnt <= '0;
        end else if (is_seed) begin
            lfsr <= crs1_rdata;
        end else if (is_samp && !samp_last) begin
            lfsr     <= lfsr_step;
            step_cnt <= step_cnt + 1'b1;
        end else if (is_samp) begin
            step_cnt <= '0;                       // Ready for next sample
        end
    end

endmodule

//--- logic/cop_ctrl.sv
// Handshake FSM, input capture, unit dispatch, CPR writeback and GPR result registers
`timescale 1ns/1ps
module cop_ctrl (
    input  logic                       g_clk,
    input  logic                       g_resetn,
    input  logic                       cpu_insn_req,  // CPU offers instruction
    input  logic [cop_pkg::XLEN-1:0]   cpu_insn_enc,
    input  logic [cop_pkg::XLEN-1:0]   cpu_rs1,
    input  logic                       cpu_insn_ack,  // CPU takes response
    output logic                       cop_insn_ack,
    output logic                       cop_insn_rsp,
    output logic                       cop_wen,       // GPR write
    output logic [cop_pkg::GPR_AW-1:0] cop_waddr,
    output logic [cop_pkg::XLEN-1:0]   cop_wdata,
    output cop_pkg::cop_result_t       cop_result,
    output logic [cop_pkg::XLEN-1:0]   insn_enc,      // To decoder
    input  logic                       id_exception,
    input  cop_pkg::cop_class_t        id_class,
    input  cop_pkg::cop_sclass_t       id_subclass,
    input  logic [cop_pkg::GPR_AW-1:0] id_gpr,
    input  logic [cop_pkg::CPR_AW-1:0] id_crd,
    output logic [cop_pkg::XLEN-1:0]   gpr_rs1,       // To units
    output logic                       palu_ivalid,
    output logic                       rng_ivalid,
    input  logic                       palu_done,
    input  logic                       palu_wen,
    input  logic [cop_pkg::XLEN-1:0]   palu_wdata,
    input  logic                       rng_done,
    input  logic                       rng_wen,
    input  logic [cop_pkg::XLEN-1:0]   rng_wdata,
    output logic                       crd_wen,       // CPR write port
    output logic [cop_pkg::CPR_AW-1:0] crd_addr,
    output logic [cop_pkg::XLEN-1:0]   crd_wdata
);
    import cop_pkg::*;

    logic [1:0]      fsm;
    logic [1:0]      n_fsm;
    logic            n_ack;
    logic            n_rsp;
    logic [XLEN-1:0] r_insn_enc;                      // Captured encoding
    logic [XLEN-1:0] r_rs1;                           // Captured rs1
    logic            insn_accept;
    logic            insn_retired;
    logic            insn_valid;
    logic            insn_finish;
    logic            exec_ok;

    assign insn_accept  = cpu_insn_req && cop_insn_ack;
    assign insn_retired = cop_insn_rsp && cpu_insn_ack;
    assign insn_valid   = insn_accept || (fsm == FSM_EXECUTING);

    // Live on accept, captured afterward
    assign insn_enc = insn_accept ? cpu_insn_enc : r_insn_enc;
    assign gpr_rs1  = insn_accept ? cpu_rs1      : r_rs1;

    always_ff @(posedge g_clk) begin
        if (insn_accept) begin
            r_insn_enc <= cpu_insn_enc;
            r_rs1      <= cpu_rs1;
        end
    end

    // Dispatch by class, illegal instructions go nowhere
    assign exec_ok     = insn_valid && !id_exception;
    assign palu_ivalid = exec_ok && (id_class == ICLASS_MOVE || id_class == ICLASS_BITWISE);
    assign rng_ivalid  = exec_ok && (id_class == ICLASS_RANDOM);
    assign insn_finish = palu_done || rng_done || (id_exception && insn_accept);

    // Units drive zero when idle
    assign crd_wen   = palu_wen | rng_wen;
    assign crd_addr  = id_crd;
    assign crd_wdata = palu_wdata | rng_wdata;

    always_comb begin
        n_fsm = fsm;
        n_ack = 1'b0;
        n_rsp = 1'b0;
        case (fsm)
            FSM_IDLE: begin
                n_fsm = FSM_WAITING;
                n_ack = 1'b1;
            end
            FSM_WAITING: begin
                if (insn_accept) begin
                    n_fsm = insn_finish ? FSM_FINISHED : FSM_EXECUTING;
                    n_rsp = insn_finish;              // Single-cycle path
                end else begin
                    n_ack = 1'b1;
                end
            end
            FSM_EXECUTING: begin
                if (insn_finish) begin
                    n_fsm = FSM_FINISHED;
                    n_rsp = 1'b1;
                end
            end
            default: begin                            // Finished, wait for CPU
                if (insn_retired) begin
                    n_fsm = FSM_WAITING;
                    n_ack = 1'b1;
                end else begin
                    n_rsp = 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            fsm          <= FSM_IDLE;
            cop_insn_ack <= 1'b0;
            cop_insn_rsp <= 1'b0;
        end else begin
            fsm          <= n_fsm;
            cop_insn_ack <= n_ack;
            cop_insn_rsp <= n_rsp;
        end
    end

    // GPR result, held while rsp is high
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cop_wen    <= 1'b0;
            cop_result <= INSN_SUCCESS;
        end else if (insn_finish) begin
            cop_wen    <= !id_exception &&
                          (id_subclass == SCLASS_XCR2GPR || id_subclass == SCLASS_RTEST);
            cop_result <= id_exception ? INSN_BAD_INS : INSN_SUCCESS;
        end
    end

    always_ff @(posedge g_clk) begin
        if (insn_finish) begin
            cop_waddr <= id_gpr;
            cop_wdata <= palu_wdata | rng_wdata;      // Only the finishing unit drives
        end
    end

endmodule

//--- logic/cop_top.sv
// Co-processor top level connecting control, decoder, register file and units
`timescale 1ns/1ps
module cop_top (
    input  logic                       g_clk,
    input  logic                       g_resetn,
    input  logic                       cpu_insn_req,
    input  logic [cop_pkg::XLEN-1:0]   cpu_insn_enc,
    input  logic [cop_pkg::XLEN-1:0]   cpu_rs1,
    output logic                       cop_insn_ack,
    output logic                       cop_insn_rsp,
    input  logic                       cpu_insn_ack,
    output logic                       cop_wen,
    output logic [cop_pkg::GPR_AW-1:0] cop_waddr,
    output logic [cop_pkg::XLEN-1:0]   cop_wdata,
    output cop_pkg::cop_result_t       cop_result
);
    import cop_pkg::*;

    logic [XLEN-1:0]   insn_enc;                   // Live or captured word
    logic [XLEN-1:0]   gpr_rs1;
    logic              id_exception;
    cop_class_t        id_class;
    cop_sclass_t       id_subclass;
    logic [CPR_AW-1:0] id_crd;
    logic [CPR_AW-1:0] id_crs1;
    logic [CPR_AW-1:0] id_crs2;
    logic [GPR_AW-1:0] id_gpr;
    logic [XLEN-1:0]   id_imm;
    logic [XLEN-1:0]   crs1_rdata;
    logic [XLEN-1:0]   crs2_rdata;
    logic              crd_wen;
    logic [CPR_AW-1:0] crd_addr;
    logic [XLEN-1:0]   crd_wdata;
    logic              palu_ivalid;
    logic              palu_done;
    logic              palu_wen;
    logic [XLEN-1:0]   palu_wdata;
    logic              rng_ivalid;
    logic              rng_done;
    logic              rng_wen;
    logic [XLEN-1:0]   rng_wdata;

    cop_ctrl u_ctrl (
        .g_clk, .g_resetn, .cpu_insn_req, .cpu_insn_enc, .cpu_rs1, .cpu_insn_ack,
        .cop_insn_ack, .cop_insn_rsp, .cop_wen, .cop_waddr, .cop_wdata, .cop_result,
        .insn_enc, .id_exception, .id_class, .id_subclass, .id_gpr, .id_crd,
        .gpr_rs1, .palu_ivalid, .rng_ivalid,
        .palu_done, .palu_wen, .palu_wdata, .rng_done, .rng_wen, .rng_wdata,
        .crd_wen, .crd_addr, .crd_wdata
    );

    cop_decode u_decode (
        .insn_enc, .id_exception, .id_class, .id_subclass,
        .id_crd, .id_crs1, .id_crs2, .id_gpr, .id_imm
    );

    cop_cprs u_cprs (
        .g_clk, .g_resetn,
        .crs1_addr (id_crs1), .crs1_rdata,         // Read addresses from decode
        .crs2_addr (id_crs2), .crs2_rdata,
        .crd_wen, .crd_addr, .crd_wdata
    );

    cop_palu u_palu (
        .palu_ivalid, .id_subclass, .gpr_rs1, .crs1_rdata, .crs2_rdata, .id_imm,
        .palu_done, .palu_wen, .palu_wdata
    );

    cop_rng u_rng (
        .g_clk, .g_resetn, .rng_ivalid, .id_subclass, .crs1_rdata,
        .rng_done, .rng_wen, .rng_wdata
    );

endmodule

//--- test/tb_cop_top.sv
// Testbench for cop_top with CPU handshake model, CPR and LFSR reference model, assertions and watchdog
`timescale 1ns/1ps
module tb_cop_top;
    import cop_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_INSN     = 112;                    // Upper bound on issued instructions
    localparam int WD_TIME    = N_INSN * (RNG_STEPS + 8) * CLK_PERIOD + 4000;

    logic              g_clk;
    logic              g_resetn;
    logic              cpu_insn_req;
    logic [XLEN-1:0]   cpu_insn_enc;
    logic [XLEN-1:0]   cpu_rs1;
    logic              cop_insn_ack;
    logic              cop_insn_rsp;
    logic              cpu_insn_ack;
    logic              cop_wen;
    logic [GPR_AW-1:0] cop_waddr;
    logic [XLEN-1:0]   cop_wdata;
    cop_result_t       cop_result;

    logic [XLEN-1:0]   cpr_m [CPR_COUNT];               // Model CPRs
    logic [XLEN-1:0]   lfsr_m;                          // Model LFSR state
    int                val_errs;
    int                proto_errs;
    int                n_issued;

    cop_top DUT (
        .g_clk, .g_resetn, .cpu_insn_req, .cpu_insn_enc, .cpu_rs1,
        .cop_insn_ack, .cop_insn_rsp, .cpu_insn_ack,
        .cop_wen, .cop_waddr, .cop_wdata, .cop_result
    );

    initial g_clk = 1'b0;
    always #(CLK_PERIOD / 2) g_clk = ~g_clk;

    // Held response must not move and ack must stay low
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        (cop_insn_rsp && !cpu_insn_ack) |=> (cop_insn_rsp && !cop_insn_ack &&
        $stable(cop_wdata) && $stable(cop_result) && $stable(cop_wen) && $stable(cop_waddr)))
    else begin
        $display("Response changed or ack rose while the CPU held back at %0t", $time);
        proto_errs++;
    end

    // Ack returns the cycle after retirement
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        (cop_insn_rsp && cpu_insn_ack) |=> (cop_insn_ack && !cop_insn_rsp))
    else begin
        $display("Ack did not return right after retirement at %0t", $time);
        proto_errs++;
    end

    assert property (@(posedge g_clk) disable iff (!g_resetn)
        (cpu_insn_req && cop_insn_ack) |=> !cop_insn_ack)
    else begin
        $display("Ack stayed high after an accept at %0t", $time);
        proto_errs++;
    end

    // One instruction in flight
    assert property (@(posedge g_clk) disable iff (!g_resetn) !(cop_insn_ack && cop_insn_rsp))
    else begin
        $display("Ack and response high together at %0t", $time);
        proto_errs++;
    end

    initial begin
        #(WD_TIME);
        $display("Watchdog expired after %0d ns with %0d instructions issued", WD_TIME, n_issued);
        $display(">>> FAIL");
        $finish;
    end

    task automatic check_val(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
        assert (got == exp) else begin
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
            val_errs++;
        end
    endtask

    function automatic logic [XLEN-1:0] enc_r(input cop_class_t cls, input cop_sclass_t sc,
        input logic [3:0] crd, input logic [3:0] crs1, input logic [3:0] crs2,
        input logic [4:0] gpr);
        return {cls, sc, crs2, gpr, crs1, crd, COP_OPCODE};
    endfunction

    function automatic logic [XLEN-1:0] enc_i(input cop_class_t cls, input cop_sclass_t sc,
        input logic [3:0] crd, input logic [8:0] imm);
        return {cls, sc, imm, 4'd0, crd, COP_OPCODE};
    endfunction

    // Galois right shift, taps applied when bit 0 drops out
    function automatic logic [XLEN-1:0] lfsr_next(input logic [XLEN-1:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic logic [XLEN-1:0] bitwise_ref(input cop_sclass_t op,
        input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        case (op)
            SCLASS_AND: return a & b;
            SCLASS_OR:  return a | b;
            SCLASS_XOR: return a ^ b;
            default:    return ~a;                    // NOT ignores crs2
        endcase
    endfunction

    // CPU side, starts and ends on a falling edge
    task automatic issue(input logic [XLEN-1:0] enc, input logic [XLEN-1:0] rs1,
        input int exp_lat, input logic exp_wen, input logic [4:0] exp_waddr,
        input logic [XLEN-1:0] exp_wdata, input cop_result_t exp_res);
        int lat;
        int hold;
        cpu_insn_req = 1'b1;
        cpu_insn_enc = enc;
        cpu_rs1      = rs1;
        while (!cop_insn_ack) @(negedge g_clk);       // Accept on next rising edge
        @(negedge g_clk);
        cpu_insn_req = 1'b0;
        cpu_insn_enc = $urandom;                      // Capture must hold the old word
        cpu_rs1      = $urandom;
        lat = 1;
        while (!cop_insn_rsp) begin
            @(negedge g_clk);
            lat++;
        end
        assert (lat == exp_lat) else begin
            $display("Response came %0d cycles after accept, expected %0d", lat, exp_lat);
            val_errs++;
        end
        check_val("cop_wen", 32'(cop_wen), 32'(exp_wen));
        check_val("cop_result", 32'(cop_result), 32'(exp_res));
        if (exp_wen) begin
            check_val("cop_waddr", 32'(cop_waddr), 32'(exp_waddr));
            check_val("cop_wdata", cop_wdata, exp_wdata);
        end
        hold = $urandom_range(3, 0);                  // Back-pressure
        repeat (hold) @(negedge g_clk);
        cpu_insn_ack = 1'b1;
        @(negedge g_clk);
        cpu_insn_ack = 1'b0;
        n_issued++;
    endtask

    task automatic write_cpr(input logic [3:0] d, input logic [XLEN-1:0] v);
        issue(enc_r(ICLASS_MOVE, SCLASS_GPR2XCR, d, 4'($urandom), 4'($urandom), 5'($urandom)),
              v, 1, 1'b0, 5'd0, '0, INSN_SUCCESS);
        cpr_m[d] = v;
    endtask

    task automatic read_cpr(input logic [3:0] s);
        logic [4:0] g;
        g = 5'($urandom);
        issue(enc_r(ICLASS_MOVE, SCLASS_XCR2GPR, 4'($urandom), s, 4'($urandom), g),
              $urandom, 1, 1'b1, g, cpr_m[s], INSN_SUCCESS);
    endtask

    task automatic load_imm(input logic [3:0] d, input logic [8:0] imm);
        issue(enc_i(ICLASS_MOVE, SCLASS_LDI, d, imm), $urandom, 1, 1'b0, 5'd0, '0, INSN_SUCCESS);
        cpr_m[d] = {23'd0, imm};                      // Zero-extended
    endtask

    task automatic bitwise_op(input cop_sclass_t op);
        logic [3:0]      d;
        logic [3:0]      s1;
        logic [3:0]      s2;
        logic [XLEN-1:0] res;
        d   = 4'($urandom);
        s1  = 4'($urandom);
        s2  = 4'($urandom);
        res = bitwise_ref(op, cpr_m[s1], cpr_m[s2]);  // Before d is overwritten
        issue(enc_r(ICLASS_BITWISE, op, d, s1, s2, 5'($urandom)), $urandom, 1, 1'b0, 5'd0, '0,
              INSN_SUCCESS);
        cpr_m[d] = res;
        read_cpr(d);
    endtask

    // Seed, sample, read back, then test for nonzero
    task automatic random_round(input logic [XLEN-1:0] seed_val);
        logic [3:0] s;
        logic [3:0] d;
        logic [4:0] g;
        s = 4'($urandom);
        d = 4'($urandom);
        g = 5'($urandom);
        write_cpr(s, seed_val);
        issue(enc_r(ICLASS_RANDOM, SCLASS_RSEED, 4'd0, s, 4'd0, 5'd0), $urandom, 1, 1'b0,
              5'd0, '0, INSN_SUCCESS);
        lfsr_m = cpr_m[s];
        issue(enc_r(ICLASS_RANDOM, SCLASS_RSAMP, d, 4'd0, 4'd0, 5'd0), $urandom, RNG_STEPS + 1,
              1'b0, 5'd0, '0, INSN_SUCCESS);
        repeat (RNG_STEPS) lfsr_m = lfsr_next(lfsr_m);
        cpr_m[d] = lfsr_m;
        read_cpr(d);
        issue(enc_r(ICLASS_RANDOM, SCLASS_RTEST, 4'd0, 4'd0, 4'd0, g), $urandom, 1, 1'b1, g,
              {31'd0, lfsr_m != '0}, INSN_SUCCESS);
    endtask

    task automatic illegal_insn(input logic [XLEN-1:0] enc);
        issue(enc, $urandom, 1, 1'b0, 5'd0, '0, INSN_BAD_INS);
        read_cpr(enc[10:7]);                          // Target CPR untouched
    endtask

    initial begin
        cop_sclass_t bit_ops [4];
        logic [3:0]  d;
        bit_ops = '{SCLASS_AND, SCLASS_OR, SCLASS_XOR, SCLASS_NOT};
        void'($urandom(32'hf7bc));
        val_errs     = 0;
        proto_errs   = 0;
        n_issued     = 0;
        lfsr_m       = '0;
        g_resetn     = 1'b0;
        cpu_insn_req = 1'b0;
        cpu_insn_enc = '0;
        cpu_rs1      = '0;
        cpu_insn_ack = 1'b0;
        foreach (cpr_m[i]) cpr_m[i] = '0;
        repeat (2) @(posedge g_clk);
        @(negedge g_clk);
        check_val("cop_insn_ack", 32'(cop_insn_ack), 32'd0);
        check_val("cop_insn_rsp", 32'(cop_insn_rsp), 32'd0);
        check_val("cop_wen", 32'(cop_wen), 32'd0);
        g_resetn = 1'b1;
        @(negedge g_clk);
        check_val("cop_insn_ack", 32'(cop_insn_ack), 32'd1); // One cycle after release

        for (int k = 0; k < 8; k++) begin                 // Move and LDI round trips
            d = 4'($urandom);
            write_cpr(d, $urandom);
            read_cpr(d);
            d = 4'($urandom);
            load_imm(d, 9'($urandom));
            read_cpr(d);
        end

        for (int i = 0; i < CPR_COUNT; i++) write_cpr(4'(i), $urandom);
        for (int r = 0; r < 3; r++) begin
            foreach (bit_ops[k]) bitwise_op(bit_ops[k]);
        end

        random_round($urandom | 32'd1);
        random_round($urandom | 32'h8000_0000);
        random_round('0);                                 // Zero seed stays zero

        d = 4'($urandom);
        illegal_insn({enc_i(ICLASS_MOVE, SCLASS_LDI, d, 9'h1a5)} ^ 32'd1); // Bad opcode
        illegal_insn(enc_i(4'd0, SCLASS_LDI, 4'($urandom), 9'h0ff));
        illegal_insn(enc_i(4'hf, SCLASS_LDI, 4'($urandom), 9'h13c));
        illegal_insn(enc_r(ICLASS_MOVE, SCLASS_AND, 4'($urandom), 4'd1, 4'd2, 5'd3));
        illegal_insn(enc_r(ICLASS_BITWISE, SCLASS_GPR2XCR, 4'($urandom), 4'd4, 4'd5, 5'd6));
        illegal_insn(enc_r(ICLASS_RANDOM, SCLASS_LDI, 4'($urandom), 4'd7, 4'd8, 5'd9));

        repeat (2) @(negedge g_clk);
        $display("Instructions %0d, value errors %0d, protocol errors %0d",
                 n_issued, val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
logic/cop_pkg.sv
logic/cop_decode.sv
logic/cop_cprs.sv
logic/cop_palu.sv
logic/cop_rng.sv
logic/cop_ctrl.sv
logic/cop_top.sv
test/tb_cop_top.sv

//--- Makefile
# Verilator build and run for the co-processor testbench

VERILATOR ?= verilator
TOP       ?= tb_cop_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
